// File: bench/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;
  import rv_pipe_pkg::*;

  localparam int          STORE_TIMEOUT = 2000;  // cycles
  localparam logic [31:0] LOAD_WORD     = 32'h1234_5000;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  wb_m2s_t     wb_m;
  wb_s2m_t     wb_s;

  logic [63:0] exp_q [$];  // {adr, dat} of each store in program order
  logic [63:0] head;
  logic        q_empty;
  logic        store_done;
  int          pc_idx;

  rv_core dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .wb_o        (wb_m),
    .wb_i        (wb_s)
  );

  tb_wb_mem u_mem (
    .clk         (clk),
    .imem_addr_i (imem_addr),
    .imem_data_o (imem_data),
    .wb_i        (wb_m),
    .wb_o        (wb_s)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic end_in_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end_in_failure();
  endtask

  task automatic halt_with(input string msg);
    $display("%s", msg);
    end_in_failure();
  endtask

  task automatic put_instr(input logic [31:0] instr);
    u_mem.rom[pc_idx] = instr;
    pc_idx++;
  endtask

  task automatic op_reg(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
    put_instr({f7, rs2, rs1, f3, rd, 7'b0110011});
  endtask

  task automatic op_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
    put_instr({imm, rs1, f3, rd, 7'b0010011});
  endtask

  task automatic load_word(input logic [4:0] rd, input logic [11:0] adr);
    put_instr({adr, 5'd0, 3'b010, rd, 7'b0000011});  // base x0
  endtask

  task automatic store_word(input logic [4:0] rs2, input logic [11:0] adr);
    put_instr({adr[11:5], rs2, 5'd0, 3'b010, adr[4:0], 7'b0100011});
  endtask

  task automatic branch_eq(input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [12:0] off);
    put_instr({off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011});
  endtask

  // store that must reach the bus with this data
  task automatic check_store(input logic [4:0] rs2, input logic [11:0] adr,
                             input logic [31:0] dat);
    store_word(rs2, adr);
    exp_q.push_back({20'h0, adr, dat});
  endtask

  // x1 = 100, x2 = -75, x11 = 35
  task automatic load_program();
    pc_idx        = 0;
    u_mem.ram[32] = LOAD_WORD;
    op_imm(3'b000, 5'd1, 5'd0, 12'd100);
    op_imm(3'b000, 5'd2, 5'd0, 12'hfb5);
    op_reg(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);    // add with x2 one back and x1 two back
    check_store(5'd3, 12'h100, 32'h0000_0019);  // store right behind its producer
    op_reg(7'h20, 3'b000, 5'd4, 5'd1, 5'd2);    // sub
    check_store(5'd4, 12'h104, 32'h0000_00af);
    op_reg(7'h00, 3'b111, 5'd5, 5'd1, 5'd2);    // and
    check_store(5'd5, 12'h108, 32'h0000_0024);
    op_reg(7'h00, 3'b110, 5'd6, 5'd1, 5'd2);    // or
    check_store(5'd6, 12'h10c, 32'hffff_fff5);
    op_reg(7'h00, 3'b100, 5'd7, 5'd1, 5'd2);    // xor
    check_store(5'd7, 12'h110, 32'hffff_ffd1);
    op_reg(7'h00, 3'b010, 5'd8, 5'd2, 5'd1);    // slt with -75 < 100
    check_store(5'd8, 12'h114, 32'h0000_0001);
    op_reg(7'h00, 3'b010, 5'd9, 5'd1, 5'd2);    // slt with 100 < -75
    check_store(5'd9, 12'h118, 32'h0000_0000);
    op_imm(3'b000, 5'd11, 5'd0, 12'd35);        // shifts use only 35 & 31 = 3
    op_reg(7'h00, 3'b001, 5'd10, 5'd1, 5'd11);  // sll
    check_store(5'd10, 12'h11c, 32'h0000_0320);
    op_reg(7'h00, 3'b101, 5'd12, 5'd2, 5'd11);  // srl
    check_store(5'd12, 12'h120, 32'h1fff_fff6);
    op_reg(7'h20, 3'b101, 5'd13, 5'd2, 5'd11);  // sra of a negative value
    check_store(5'd13, 12'h124, 32'hffff_fff6);
    op_imm(3'b111, 5'd14, 5'd2, 12'h0f0);       // andi
    check_store(5'd14, 12'h128, 32'h0000_00b0);
    op_imm(3'b110, 5'd15, 5'd1, 12'hf00);       // ori with immediate -256
    check_store(5'd15, 12'h12c, 32'hffff_ff64);
    op_imm(3'b100, 5'd16, 5'd1, 12'h7ff);       // xori
    check_store(5'd16, 12'h130, 32'h0000_079b);
    op_imm(3'b010, 5'd17, 5'd2, 12'hfb6);       // slti with -75 < -74
    check_store(5'd17, 12'h134, 32'h0000_0001);
    op_imm(3'b000, 5'd0, 5'd1, 12'd5);          // write to x0 is dropped
    check_store(5'd0, 12'h138, 32'h0000_0000);
    load_word(5'd18, 12'h080);
    op_reg(7'h00, 3'b000, 5'd19, 5'd18, 5'd1);  // load-use
    check_store(5'd19, 12'h13c, LOAD_WORD + 32'd100);
    branch_eq(5'd1, 5'd1, 13'd12);              // taken
    store_word(5'd1, 12'h140);                  // flushed
    store_word(5'd2, 12'h144);                  // flushed
    branch_eq(5'd1, 5'd2, 13'd8);               // not taken
    check_store(5'd3, 12'h148, 32'h0000_0019);
  endtask

  assign store_done = wb_m.cyc && wb_m.stb && wb_m.we && wb_s.ack;

  // head of the expected stores moves on at each acked write
  always @(posedge clk) begin
    if (rst_n && store_done && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
    end
    q_empty <= exp_q.size() == 0;
    head    <= (exp_q.size() != 0) ? exp_q[0] : '0;
  end

  a_rst_pc: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> imem_addr == 32'h0)
    else flag_mismatch("imem_addr_o", $sampled(imem_addr), 32'h0);
  a_rst_bus: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |->
                              !wb_m.cyc && !wb_m.stb && !wb_m.we)
    else halt_with("wb_o.cyc, wb_o.stb or wb_o.we high during or right after reset");

  a_store_known: assert property (@(posedge clk) disable iff (!rst_n) store_done |-> !q_empty)
    else halt_with("store on the bus where the program makes none");
  a_store_adr: assert property (@(posedge clk) disable iff (!rst_n)
                                store_done |-> wb_m.adr == head[63:32])
    else flag_mismatch("wb_o.adr", $sampled(wb_m.adr), $sampled(head[63:32]));
  a_store_dat: assert property (@(posedge clk) disable iff (!rst_n)
                                store_done |-> wb_m.dat == head[31:0])
    else flag_mismatch("wb_o.dat", $sampled(wb_m.dat), $sampled(head[31:0]));

  a_cyc_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_m.cyc == wb_m.stb)
    else halt_with("wb_o.cyc and wb_o.stb differ");
  a_sel: assert property (@(posedge clk) disable iff (!rst_n)
                          wb_m.cyc |-> wb_m.sel == 4'hf)
    else flag_mismatch("wb_o.sel", 32'($sampled(wb_m.sel)), 32'h0000_000f);
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
                           wb_m.stb && !wb_s.ack |=> wb_m.stb && $stable(wb_m.adr) &&
                           $stable(wb_m.we) && $stable(wb_m.dat))
    else halt_with("bus request dropped or changed before ack");
  a_drop: assert property (@(posedge clk) disable iff (!rst_n)
                           wb_m.stb && wb_s.ack |=> !wb_m.cyc && !wb_m.stb)
    else halt_with("wb_o.cyc or wb_o.stb still high the cycle after ack");

  initial begin
    int cycles;
    rst_n = 1'b1;
    #1;                // memory model has filled its arrays at time 0
    rst_n = 1'b0;      // falling edge clears the core before the first clock
    load_program();
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < STORE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() == 0) begin
      repeat (20) @(posedge clk);  // a repeated or stray store would show up here
      $display("TEST PASSED");
      $finish;
    end else begin
      halt_with("timed out waiting for the expected stores");
    end
  end

endmodule

// File: bench/tb_wb_mem.sv
`timescale 1ns/1ns

module tb_wb_mem (
  input  logic                 clk,
  input  logic [31:0]          imem_addr_i,
  output logic [31:0]          imem_data_o,
  input  rv_pipe_pkg::wb_m2s_t wb_i,
  output rv_pipe_pkg::wb_s2m_t wb_o
);
  logic [31:0] rom [0:63];   // program, loaded by the testbench top
  logic [31:0] ram [0:255];
  logic [31:0] lfsr_q;
  logic [1:0]  wait_left;    // wait states before the next ack

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit of the wait count
  task automatic draw_wait();
    lfsr_q       = lfsr_next(lfsr_q);
    wait_left[0] = lfsr_q[0];
    lfsr_q       = lfsr_next(lfsr_q);
    wait_left[1] = lfsr_q[0];
  endtask

  initial begin
    wb_o   = '0;
    lfsr_q = 32'h7fc0_9da4;
    draw_wait();
    for (int i = 0; i < 64; i++) begin
      rom[i] = 32'h0000_0013;  // addi x0, x0, 0
    end
    for (int i = 0; i < 256; i++) begin
      ram[i] = 32'hd000_0000 + 32'(i * 4);  // word holds its own byte address
    end
  end

  // fetch port reads like a rom
  assign imem_data_o = rom[imem_addr_i[7:2]];

  // classic slave, ack after 0 to 3 wait states, dropped once the master lets go
  always @(posedge clk) begin
    #1;
    if (wb_i.cyc && wb_i.stb && !wb_o.ack) begin
      if (wait_left == 2'd0) begin
        wb_o.ack = 1'b1;
        if (wb_i.we) begin
          ram[wb_i.adr[9:2]] = wb_i.dat;
        end else begin
          wb_o.dat = ram[wb_i.adr[9:2]];
        end
        draw_wait();
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end else begin
      wb_o.ack = 1'b0;
    end
  end

endmodule

// File: files.f
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_regfile.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_hazard_unit.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
bench/tb_wb_mem.sv
bench/tb_rv_core.sv

// File: hdl/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
  input  logic [rv_isa_pkg::XLEN-1:0] a_i,
  input  logic [rv_isa_pkg::XLEN-1:0] b_i,
  input  rv_isa_pkg::alu_op_e         op_i,
  output logic [rv_isa_pkg::XLEN-1:0] result_o
);
  import rv_isa_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD: result_o = a_i + b_i;
      ALU_SUB: result_o = a_i - b_i;
      ALU_AND: result_o = a_i & b_i;
      ALU_OR:  result_o = a_i | b_i;
      ALU_XOR: result_o = a_i ^ b_i;
      ALU_SLT: result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      ALU_SLL: result_o = a_i << shamt;
      ALU_SRL: result_o = a_i >> shamt;
      ALU_SRA: result_o = $unsigned($signed(a_i) >>> shamt);
      default: result_o = '0;
    endcase
  end

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ns

module rv_core (
  input  logic                 clk,
  input  logic                 rst_n,
  output logic [31:0]          imem_addr_o,
  input  logic [31:0]          imem_data_i,
  output rv_pipe_pkg::wb_m2s_t wb_o,
  input  rv_pipe_pkg::wb_s2m_t wb_i
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] if_id_pc_q;
  logic [XLEN-1:0] if_id_instr_q;
  id_ex_t          id_ex_q;
  id_ex_t          id_ex_d;
  ex_mem_t         ex_mem_q;
  ex_mem_t         ex_mem_d;
  mem_wb_t         mem_wb_q;
  mem_wb_t         mem_wb_d;

  ctrl_t           dec_ctrl;
  logic [XLEN-1:0] dec_imm;
  logic [XLEN-1:0] rf_rs1_data;
  logic [XLEN-1:0] rf_rs2_data;

  fwd_sel_e        fwd_a;
  fwd_sel_e        fwd_b;
  fwd_sel_e        fwd_st;
  logic            hz_stall;
  logic            lsu_busy;
  logic [XLEN-1:0] load_data;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b_reg;   // forwarded rs2, before the immediate mux
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] st_data;
  logic [XLEN-1:0] alu_result;
  logic            branch_taken;
  logic [XLEN-1:0] branch_target;

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                              input logic [XLEN-1:0] reg_val,
                                              input logic [XLEN-1:0] mem_val,
                                              input logic [XLEN-1:0] wb_val);
    case (sel)
      FWD_MEM: fwd_mux = mem_val;
      FWD_WB:  fwd_mux = wb_val;
      default: fwd_mux = reg_val;
    endcase
  endfunction

  assign imem_addr_o = pc_q;

  // fetch, flush wins over the load-use hold
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= '0;
      if_id_pc_q    <= '0;
      if_id_instr_q <= NOP_INSTR;
    end else if (!lsu_busy) begin
      if (branch_taken) begin
        pc_q          <= branch_target;
        if_id_instr_q <= NOP_INSTR;
      end else if (!hz_stall) begin
        pc_q          <= pc_q + 32'd4;
        if_id_pc_q    <= pc_q;
        if_id_instr_q <= imem_data_i;
      end
    end
  end

  rv_regfile u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs1_addr_i (if_id_instr_q[19:15]),
    .rs2_addr_i (if_id_instr_q[24:20]),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data),
    .wr_en_i    (mem_wb_q.reg_wr_en),
    .wr_addr_i  (mem_wb_q.rd),
    .wr_data_i  (mem_wb_q.wb_data)
  );

  rv_decoder u_decoder (
    .instr_i (if_id_instr_q),
    .ctrl_o  (dec_ctrl),
    .imm_o   (dec_imm)
  );

  always_comb begin
    id_ex_d.pc       = if_id_pc_q;
    id_ex_d.rs1      = if_id_instr_q[19:15];
    id_ex_d.rs2      = if_id_instr_q[24:20];
    id_ex_d.rd       = if_id_instr_q[11:7];
    id_ex_d.rs1_data = rf_rs1_data;
    id_ex_d.rs2_data = rf_rs2_data;
    id_ex_d.imm      = dec_imm;
    id_ex_d.ctrl     = dec_ctrl;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_q <= '0;
    end else if (!lsu_busy) begin
      id_ex_q <= (branch_taken || hz_stall) ? '0 : id_ex_d;  // bubble
    end
  end

  rv_hazard_unit u_hazard (
    .id_ex_i     (id_ex_q),
    .ex_mem_i    (ex_mem_q),
    .mem_wb_i    (mem_wb_q),
    .if_id_rs1_i (if_id_instr_q[19:15]),
    .if_id_rs2_i (if_id_instr_q[24:20]),
    .fwd_a_o     (fwd_a),
    .fwd_b_o     (fwd_b),
    .fwd_st_o    (fwd_st),
    .stall_o     (hz_stall)
  );

  assign op_a     = fwd_mux(fwd_a, id_ex_q.rs1_data, ex_mem_q.alu_result, mem_wb_q.wb_data);
  assign op_b_reg = fwd_mux(fwd_b, id_ex_q.rs2_data, ex_mem_q.alu_result, mem_wb_q.wb_data);
  assign st_data  = fwd_mux(fwd_st, id_ex_q.rs2_data, ex_mem_q.alu_result, mem_wb_q.wb_data);
  assign op_b     = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : op_b_reg;

  rv_alu u_alu (
    .a_i      (op_a),
    .b_i      (op_b),
    .op_i     (id_ex_q.ctrl.alu_op),
    .result_o (alu_result)
  );

  // beq resolves here, the two younger slots get flushed
  assign branch_taken  = id_ex_q.ctrl.is_branch && (op_a == op_b_reg);
  assign branch_target = id_ex_q.pc + id_ex_q.imm;

  always_comb begin
    ex_mem_d.rd         = id_ex_q.rd;
    ex_mem_d.alu_result = alu_result;
    ex_mem_d.store_data = st_data;
    ex_mem_d.ctrl       = id_ex_q.ctrl;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem_q <= '0;
    end else if (!lsu_busy) begin
      ex_mem_q <= ex_mem_d;
    end
  end

  rv_lsu u_lsu (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_mem_i    (ex_mem_q),
    .wb_o        (wb_o),
    .wb_i        (wb_i),
    .busy_o      (lsu_busy),
    .load_data_o (load_data)
  );

  always_comb begin
    mem_wb_d.rd        = ex_mem_q.rd;
    mem_wb_d.wb_data   = ex_mem_q.ctrl.mem_rd ? load_data : ex_mem_q.alu_result;
    mem_wb_d.reg_wr_en = ex_mem_q.ctrl.reg_wr_en;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_wb_q <= '0;
    end else if (!lsu_busy) begin
      mem_wb_q <= mem_wb_d;
    end
  end

endmodule

// File: hdl/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
  input  logic [31:0]        instr_i,
  output rv_pipe_pkg::ctrl_t ctrl_o,
  output logic [31:0]        imm_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [2:0] funct3;
  logic       f7_b5;

  assign funct3 = instr_i[14:12];
  assign f7_b5  = instr_i[30];

  function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic alt,
                                        input logic allow_sub);
    case (f3)
      F3_ADD_SUB: alu_op_of = (allow_sub && alt) ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_op_of = ALU_SLL;
      F3_SLT:     alu_op_of = ALU_SLT;
      F3_XOR:     alu_op_of = ALU_XOR;
      F3_SR:      alu_op_of = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_op_of = ALU_OR;
      F3_AND:     alu_op_of = ALU_AND;
      default:    alu_op_of = ALU_ADD;  // sltu not supported
    endcase
  endfunction

  always_comb begin
    ctrl_o = '0;
    imm_o  = '0;
    case (opcode_e'(instr_i[6:0]))
      OP_RTYPE: begin
        ctrl_o.reg_wr_en = 1'b1;
        ctrl_o.alu_op    = alu_op_of(funct3, f7_b5, 1'b1);
      end
      OP_ITYPE: begin
        ctrl_o.reg_wr_en   = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.alu_op      = alu_op_of(funct3, f7_b5, 1'b0);  // bit 30 is immediate here
        imm_o              = {{20{instr_i[31]}}, instr_i[31:20]};
      end
      OP_LOAD: begin
        ctrl_o.reg_wr_en   = 1'b1;
        ctrl_o.mem_rd      = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.alu_op      = ALU_ADD;
        imm_o              = {{20{instr_i[31]}}, instr_i[31:20]};
      end
      OP_STORE: begin
        ctrl_o.mem_wr      = 1'b1;
        ctrl_o.alu_src_imm = 1'b1;
        ctrl_o.alu_op      = ALU_ADD;
        imm_o              = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      end
      OP_BRANCH: begin
        ctrl_o.is_branch = 1'b1;
        ctrl_o.alu_op    = ALU_SUB;
        imm_o            = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                            instr_i[30:25], instr_i[11:8], 1'b0};
      end
      default: ;  // zero control word behaves as a nop
    endcase
  end

endmodule

// File: hdl/rv_hazard_unit.sv
`timescale 1ns/1ns

module rv_hazard_unit (
  input  rv_pipe_pkg::id_ex_t               id_ex_i,
  input  rv_pipe_pkg::ex_mem_t              ex_mem_i,
  input  rv_pipe_pkg::mem_wb_t              mem_wb_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] if_id_rs1_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] if_id_rs2_i,
  output rv_pipe_pkg::fwd_sel_e             fwd_a_o,
  output rv_pipe_pkg::fwd_sel_e             fwd_b_o,
  output rv_pipe_pkg::fwd_sel_e             fwd_st_o,
  output logic                              stall_o
);
  import rv_pipe_pkg::*;

  logic ex_mem_wr;
  logic mem_wb_wr;

  assign ex_mem_wr = ex_mem_i.ctrl.reg_wr_en && ex_mem_i.rd != '0;
  assign mem_wb_wr = mem_wb_i.reg_wr_en && mem_wb_i.rd != '0;

  // the younger producer in ex/mem takes priority over mem/wb
  function automatic fwd_sel_e src_sel(input logic [4:0] src);
    if (ex_mem_wr && ex_mem_i.rd == src) begin
      src_sel = FWD_MEM;
    end else if (mem_wb_wr && mem_wb_i.rd == src) begin
      src_sel = FWD_WB;
    end else begin
      src_sel = FWD_REG;
    end
  endfunction

  always_comb begin
    fwd_a_o  = src_sel(id_ex_i.rs1);
    fwd_b_o  = id_ex_i.ctrl.alu_src_imm ? FWD_REG : src_sel(id_ex_i.rs2);
    fwd_st_o = id_ex_i.ctrl.mem_wr ? src_sel(id_ex_i.rs2) : FWD_REG;
  end

  // load data only exists after the memory stage, so hold the consumer one cycle
  assign stall_o = id_ex_i.ctrl.mem_rd && id_ex_i.rd != '0 &&
                   (id_ex_i.rd == if_id_rs1_i || id_ex_i.rd == if_id_rs2_i);

endmodule

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OP_RTYPE  = 7'b0110011,
    OP_ITYPE  = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011
  } opcode_e;

  // funct3 field, instr[14:12]
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;  // srl or sra, split by funct7 bit 5
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5,
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7,
    ALU_SRA = 4'd8
  } alu_op_e;

endpackage

// File: hdl/rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_pipe_pkg::ex_mem_t ex_mem_i,
  output rv_pipe_pkg::wb_m2s_t wb_o,
  input  rv_pipe_pkg::wb_s2m_t wb_i,
  output logic                 busy_o,
  output logic [31:0]          load_data_o
);
  import rv_pipe_pkg::*;

  typedef enum logic {
    LSU_IDLE,
    LSU_WAIT
  } lsu_state_e;

  lsu_state_e  state_q;
  logic        done_q;       // set for the one cycle after ack
  logic        req;
  logic        cyc;
  logic [31:0] load_data_q;

  assign req    = (ex_mem_i.ctrl.mem_rd || ex_mem_i.ctrl.mem_wr) && !done_q;
  assign busy_o = req;
  assign cyc    = (state_q == LSU_WAIT) || req;

  always_comb begin
    wb_o.cyc = cyc;
    wb_o.stb = cyc;
    wb_o.we  = ex_mem_i.ctrl.mem_wr;
    wb_o.adr = ex_mem_i.alu_result;
    wb_o.dat = ex_mem_i.store_data;
    wb_o.sel = 4'hf;  // word accesses only
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= LSU_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= cyc && wb_i.ack;  // pipeline advances while this is high
      case (state_q)
        LSU_IDLE: if (req && !wb_i.ack) state_q <= LSU_WAIT;
        LSU_WAIT: if (wb_i.ack) state_q <= LSU_IDLE;
        default:  state_q <= LSU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cyc && wb_i.ack && !ex_mem_i.ctrl.mem_wr) begin
      load_data_q <= wb_i.dat;  // sampled at ack
    end
  end

  assign load_data_o = load_data_q;

endmodule

// File: hdl/rv_pipe_pkg.sv
package rv_pipe_pkg;

  typedef struct packed {
    logic                reg_wr_en;    // writes rd
    logic                mem_rd;       // lw
    logic                mem_wr;       // sw
    logic                alu_src_imm;  // operand b is the immediate
    logic                is_branch;    // beq
    rv_isa_pkg::alu_op_e alu_op;
  } ctrl_t;

  typedef enum logic [1:0] {
    FWD_REG = 2'd0,  // value read in decode
    FWD_MEM = 2'd1,  // ex/mem alu result
    FWD_WB  = 2'd2   // mem/wb write-back data
  } fwd_sel_e;

  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0]       pc;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]       rs1_data;
    logic [rv_isa_pkg::XLEN-1:0]       rs2_data;
    logic [rv_isa_pkg::XLEN-1:0]       imm;
    ctrl_t                             ctrl;
  } id_ex_t;

  typedef struct packed {
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]       alu_result;  // also the data address
    logic [rv_isa_pkg::XLEN-1:0]       store_data;
    ctrl_t                             ctrl;
  } ex_mem_t;

  typedef struct packed {
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]       wb_data;
    logic                              reg_wr_en;
  } mem_wb_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_m2s_t;

  // wishbone classic, slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

endpackage

// File: hdl/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic [rv_isa_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_isa_pkg::XLEN-1:0]       rs2_data_o,
  input  logic                              wr_en_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] wr_addr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       wr_data_i
);
  import rv_isa_pkg::*;

  logic [XLEN-1:0] regs [1:31];  // x0 is not stored

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_addr_i != '0) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // a write in this cycle is visible to decode right away
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                      (wr_en_i && wr_addr_i == rs1_addr_i) ? wr_data_i : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                      (wr_en_i && wr_addr_i == rs2_addr_i) ? wr_data_i : regs[rs2_addr_i];

endmodule
